// File: src.f
source/hb_bus_pkg.sv
source/hb_map_pkg.sv
source/hb_addr_decode.sv
source/hb_reg_tgt.sv
source/hb_resp_mux.sv
source/hb_exp_top.sv
sim/hb_exp_assert.sv
sim/hb_exp_tb.sv

// File: sim/hb_exp_tb.sv
`timescale 1ns/1ps

module hb_exp_tb
  import hb_bus_pkg::*;
  import hb_map_pkg::*;
();

  // Read sweep, write sweep, read sweep, then the random mix.
  localparam int N_SWEEP        = 2 ** HB_ADDRW;
  localparam int N_RANDOM       = 400;
  localparam int N_REQ          = 3 * N_SWEEP + N_RANDOM;
  localparam int TIMEOUT_CYCLES = 8 * N_REQ + 100;
  localparam int N_MODE         = 2;

  logic     clk = 1'b0;
  logic     i_reset;
  logic     i_rq;
  hb_addr_t i_addr;
  logic     i_wr;
  hb_data_t i_wdata;

  // One DUT per decode mode, index equals ADDR_COMP.
  wire [N_MODE-1:0]               dut_ack;
  wire [N_MODE-1:0]               dut_err;
  wire [N_MODE-1:0][HB_DATAW-1:0] dut_rdata;

  // Register image per mode.
  hb_data_t model [N_MODE][HB_NTGT*HB_NREG];

  // Expected {err, data} per mode, one entry per request.
  logic [N_MODE-1:0][HB_DATAW:0] exp_q [$];

  int seed        = 68849;
  int cycle_count = 0;
  int checked     = 0;

  always #20 clk = ~clk;

  generate
    for (genvar m = 0; m < N_MODE; m++) begin : g_mode
      hb_exp_top #(
        .ADDR_COMP (m)
      ) u_dut (
        .clk     (clk),
        .i_reset (i_reset),
        .i_rq    (i_rq),
        .i_addr  (i_addr),
        .i_wr    (i_wr),
        .i_wdata (i_wdata),
        .o_ack   (dut_ack[m]),
        .o_err   (dut_err[m]),
        .o_rdata (dut_rdata[m])
      );
    end
  endgenerate

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error: time %0t signal %s expected %b actual %b",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input hb_data_t exp, input hb_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: time %0t signal %s expected %h actual %h",
                         $time, name, exp, act));
    end
  endtask

  // Failed properties summed over both bound checkers.
  function automatic int assert_failures();
    return g_mode[0].u_dut.u_assert.n_fail + g_mode[1].u_dut.u_assert.n_fail;
  endfunction

  // Write pattern built from every address bit.
  function automatic hb_data_t fill_word(input hb_addr_t addr);
    return {8'hc3, 3'b000, addr, 3'b111, ~addr, 8'h3c};
  endfunction

  // Expected {err, data} for one access, updating the register image.
  function automatic logic [HB_DATAW:0] ref_access(input int mode, input hb_addr_t addr,
                                                   input logic wr, input hb_data_t wdata);
    int tgt;
    int off;
    int base;
    int last;
    tgt = -1;
    off = 0;
    if (mode == 0) begin
      tgt = addr[HB_ADDRW-1:HB_OFFW];
      off = addr[HB_OFFW-1:0];
    end else begin
      // Scan downward so the lowest match is the one kept.
      for (int k = HB_NTGT - 1; k >= 0; k--) begin
        base = HB_BASE_VEC[k*HB_ADDRW +: HB_ADDRW];
        last = base + HB_SPAN_VEC[k*HB_ADDRW +: HB_ADDRW];
        if ((addr >= base) && (addr <= last)) begin
          tgt = k;
          off = (addr - base) % HB_NREG;
        end
      end
    end
    if (tgt < 0) begin
      return {HB_RESP_ERR, {HB_DATAW{1'b0}}};
    end
    if (wr) begin
      if (HB_RO_MASK[tgt]) begin
        return {HB_RESP_ERR, {HB_DATAW{1'b0}}};
      end
      model[mode][tgt*HB_NREG+off] = wdata;
      return {HB_RESP_OK, {HB_DATAW{1'b0}}};
    end
    return {HB_RESP_OK, model[mode][tgt*HB_NREG+off]};
  endfunction

  // One request, then wait for both DUTs to acknowledge.
  task automatic issue(input hb_addr_t addr, input logic wr, input hb_data_t wdata);
    logic [N_MODE-1:0][HB_DATAW:0] exp;
    for (int m = 0; m < N_MODE; m++) begin
      exp[m] = ref_access(m, addr, wr, wdata);
    end
    exp_q.push_back(exp);
    @(posedge clk);
    i_rq    <= 1'b1;
    i_addr  <= addr;
    i_wr    <= wr;
    i_wdata <= wdata;
    @(posedge clk);
    i_rq <= 1'b0;
    do begin
      @(posedge clk);
    end while (dut_ack !== '1);
  endtask

  // Response three cycles after each sampled strobe.
  initial begin : compare_responses
    logic [N_MODE-1:0][HB_DATAW:0] exp;
    forever begin
      @(posedge clk);
      if (i_rq === 1'b1) begin
        repeat (3) @(posedge clk);
        if (exp_q.size() == 0) begin
          fail_run("A response arrived with no expected value queued");
        end
        exp = exp_q.pop_front();
        for (int m = 0; m < N_MODE; m++) begin
          if (dut_ack[m] !== 1'b1) begin
            fail_run($sformatf("No acknowledge from mode %0d DUT three cycles after its request",
                               m));
          end
          check_err($sformatf("g_mode[%0d].u_dut.o_err", m), exp[m][HB_DATAW], dut_err[m]);
          check_data($sformatf("g_mode[%0d].u_dut.o_rdata", m), exp[m][HB_DATAW-1:0],
                     dut_rdata[m]);
        end
        checked++;
      end
    end
  end

  // Stop at the first failed port property.
  always @(posedge clk) begin
    if (assert_failures() != 0) begin
      fail_run("An assertion on the DUT ports failed");
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                         TIMEOUT_CYCLES));
    end
  end

  initial begin : run_tests
    hb_addr_t addr;
    int       rnd;
    for (int m = 0; m < N_MODE; m++) begin
      for (int r = 0; r < HB_NTGT * HB_NREG; r++) begin
        model[m][r] = '0;
      end
    end
    i_reset <= 1'b1;
    i_rq    <= 1'b0;
    i_addr  <= '0;
    i_wr    <= 1'b0;
    i_wdata <= '0;
    repeat (8) @(posedge clk);
    i_reset <= 1'b0;
    @(posedge clk);

    // Outputs idle after reset.
    for (int m = 0; m < N_MODE; m++) begin
      if (dut_ack[m] !== 1'b0) begin
        fail_run($sformatf("o_ack of mode %0d DUT is not low after reset", m));
      end
      check_err($sformatf("g_mode[%0d].u_dut.o_err", m), HB_RESP_OK, dut_err[m]);
      check_data($sformatf("g_mode[%0d].u_dut.o_rdata", m), '0, dut_rdata[m]);
    end

    // Cleared registers, holes and overlap read first.
    for (int a = 0; a < N_SWEEP; a++) begin
      issue(hb_addr_t'(a), 1'b0, '0);
    end

    // Fill every address, read-only targets included.
    for (int a = 0; a < N_SWEEP; a++) begin
      issue(hb_addr_t'(a), 1'b1, fill_word(hb_addr_t'(a)));
    end
    for (int a = 0; a < N_SWEEP; a++) begin
      issue(hb_addr_t'(a), 1'b0, '0);
    end

    // Random mix of reads and writes.
    for (int n = 0; n < N_RANDOM; n++) begin
      addr = hb_addr_t'($random(seed));
      rnd  = $random(seed);
      issue(addr, rnd[0], $random(seed));
    end

    @(posedge clk);
    if (checked != N_REQ) begin
      fail_run($sformatf("Checked %0d responses but issued %0d requests", checked, N_REQ));
    end
    if (assert_failures() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run("An assertion on the DUT ports failed near the end of the run");
    end
  end

endmodule

// File: sim/hb_exp_assert.sv
`timescale 1ns/1ps

module hb_exp_assert
  import hb_bus_pkg::*;
(
  input logic     clk,
  input logic     i_reset,
  input logic     i_rq,
  input logic     o_ack,
  input logic     o_err,
  input hb_data_t o_rdata
);

  // High from a request until its acknowledge.
  logic pending;

  // Number of failed properties so far.
  int n_fail = 0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pending <= 1'b0;
    end else if (i_rq) begin
      pending <= 1'b1;
    end else if (o_ack) begin
      pending <= 1'b0;
    end
  end

  // Three cycles from strobe to response, checked both ways.
  a_ack_after_rq : assert property (@(posedge clk) disable iff (i_reset)
    i_rq |-> ##3 o_ack)
    else begin
      $error("o_ack did not follow i_rq after three cycles");
      n_fail++;
    end

  a_rq_before_ack : assert property (@(posedge clk) disable iff (i_reset)
    o_ack |-> $past(i_rq, 3))
    else begin
      $error("o_ack without i_rq three cycles earlier");
      n_fail++;
    end

  // Single outstanding request.
  a_one_pending : assert property (@(posedge clk) disable iff (i_reset)
    i_rq |-> !pending)
    else begin
      $error("i_rq raised while a request was outstanding");
      n_fail++;
    end

  // No data with an error.
  a_err_zero_data : assert property (@(posedge clk) disable iff (i_reset)
    o_err |-> (o_rdata == '0))
    else begin
      $error("o_rdata not zero with o_err");
      n_fail++;
    end

endmodule

bind hb_exp_top hb_exp_assert u_assert (
  .clk     (clk),
  .i_reset (i_reset),
  .i_rq    (i_rq),
  .o_ack   (o_ack),
  .o_err   (o_err),
  .o_rdata (o_rdata)
);

// File: source/hb_exp_top.sv
`timescale 1ns/1ps

module hb_exp_top
  import hb_bus_pkg::*;
  import hb_map_pkg::*;
#(
  parameter int ADDR_COMP = 0
) (
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_rq,
  input  hb_addr_t i_addr,
  input  logic     i_wr,
  input  hb_data_t i_wdata,
  output logic     o_ack,
  output logic     o_err,
  output hb_data_t o_rdata
);

  // Decoder to targets.
  logic [HB_NTGT-1:0] tgt_rq;
  logic [HB_OFFW-1:0] tgt_offset;
  logic               tgt_wr;
  hb_data_t           tgt_wdata;
  logic               miss;

  // Targets to response mux.
  logic [HB_NTGT-1:0]          tgt_ack;
  logic [HB_NTGT-1:0]          tgt_err;
  logic [HB_NTGT*HB_DATAW-1:0] tgt_rdata;

  hb_addr_decode #(
    .ADDR_COMP (ADDR_COMP)
  ) u_decode (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_rq     (i_rq),
    .i_addr   (i_addr),
    .i_wr     (i_wr),
    .i_wdata  (i_wdata),
    .o_tgt_rq (tgt_rq),
    .o_offset (tgt_offset),
    .o_wr     (tgt_wr),
    .o_wdata  (tgt_wdata),
    .o_miss   (miss)
  );

  // One register target per map entry.
  genvar k;
  generate
    for (k = 0; k < HB_NTGT; k++) begin : g_tgt
      hb_reg_tgt #(
        .RO (HB_RO_MASK[k])
      ) u_tgt (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_rq     (tgt_rq[k]),
        .i_offset (tgt_offset),
        .i_wr     (tgt_wr),
        .i_wdata  (tgt_wdata),
        .o_ack    (tgt_ack[k]),
        .o_err    (tgt_err[k]),
        .o_rdata  (tgt_rdata[k*HB_DATAW +: HB_DATAW])
      );
    end
  endgenerate

  hb_resp_mux u_resp (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_tgt_ack   (tgt_ack),
    .i_tgt_err   (tgt_err),
    .i_tgt_rdata (tgt_rdata),
    .i_miss      (miss),
    .o_ack       (o_ack),
    .o_err       (o_err),
    .o_rdata     (o_rdata)
  );

endmodule

// File: source/hb_resp_mux.sv
`timescale 1ns/1ps

module hb_resp_mux
  import hb_bus_pkg::*;
  import hb_map_pkg::*;
(
  input  logic                        clk,
  input  logic                        i_reset,
  input  logic [HB_NTGT-1:0]          i_tgt_ack,
  input  logic [HB_NTGT-1:0]          i_tgt_err,
  input  logic [HB_NTGT*HB_DATAW-1:0] i_tgt_rdata,
  input  logic                        i_miss,
  output logic                        o_ack,
  output logic                        o_err,
  output hb_data_t                    o_rdata
);

  logic     any_ack;
  logic     sel_err;
  hb_data_t sel_rdata;
  logic     miss_d;

  assign any_ack = |i_tgt_ack;

  // Acks are one-hot, so masking and OR-ing picks the responder.
  always_comb begin
    sel_err   = HB_RESP_OK;
    sel_rdata = '0;
    for (int k = 0; k < HB_NTGT; k++) begin
      sel_err   = sel_err | (i_tgt_ack[k] & i_tgt_err[k]);
      sel_rdata = sel_rdata |
                  ({HB_DATAW{i_tgt_ack[k]}} & i_tgt_rdata[k*HB_DATAW +: HB_DATAW]);
    end
  end

  // Miss waits one cycle to line up with the target path.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      miss_d <= 1'b0;
    end else begin
      miss_d <= i_miss;
    end
  end

  // Initiator response strobe and status.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_ack <= 1'b0;
      o_err <= HB_RESP_OK;
    end else begin
      o_ack <= any_ack | miss_d;
      if (miss_d) begin
        o_err <= HB_RESP_ERR;
      end else if (any_ack) begin
        o_err <= sel_err;
      end else begin
        o_err <= HB_RESP_OK;
      end
    end
  end

  // Data only on a good read.
  always_ff @(posedge clk) begin
    if (any_ack && (sel_err == HB_RESP_OK)) begin
      o_rdata <= sel_rdata;
    end else begin
      o_rdata <= '0;
    end
  end

endmodule

// File: source/hb_reg_tgt.sv
`timescale 1ns/1ps

module hb_reg_tgt
  import hb_bus_pkg::*;
#(
  parameter bit RO = 1'b0
) (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_rq,
  input  logic [HB_OFFW-1:0] i_offset,
  input  logic               i_wr,
  input  hb_data_t           i_wdata,
  output logic               o_ack,
  output logic               o_err,
  output hb_data_t           o_rdata
);

  hb_data_t regs [HB_NREG];

  logic wr_ok;
  logic wr_bad;

  // Writes land only on a writable target.
  assign wr_ok  = i_rq & i_wr & ~RO;
  assign wr_bad = i_rq & i_wr & RO;

  // Register file.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int k = 0; k < HB_NREG; k++) begin
        regs[k] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_offset] <= i_wdata;
    end
  end

  // Ack one cycle after the strobe.
  // A write to a read-only target comes back as an error.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_ack <= 1'b0;
      o_err <= HB_RESP_OK;
    end else begin
      o_ack <= i_rq;
      o_err <= wr_bad ? HB_RESP_ERR : HB_RESP_OK;
    end
  end

  // Read data, zero outside a read.
  always_ff @(posedge clk) begin
    if (i_rq && !i_wr) begin
      o_rdata <= regs[i_offset];
    end else begin
      o_rdata <= '0;
    end
  end

endmodule

// File: source/hb_addr_decode.sv
`timescale 1ns/1ps

module hb_addr_decode
  import hb_bus_pkg::*;
  import hb_map_pkg::*;
#(
  parameter int ADDR_COMP = 0
) (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_rq,
  input  hb_addr_t           i_addr,
  input  logic               i_wr,
  input  hb_data_t           i_wdata,
  output logic [HB_NTGT-1:0] o_tgt_rq,
  output logic [HB_OFFW-1:0] o_offset,
  output logic               o_wr,
  output hb_data_t           o_wdata,
  output logic               o_miss
);

  // Width of the target index field in direct mode.
  localparam int SELW = HB_ADDRW - HB_OFFW;

  logic [HB_NTGT-1:0] tgt_sel;
  logic [HB_OFFW-1:0] tgt_off;

  generate
    if (ADDR_COMP == 0) begin : g_direct

      // Upper bits name the target, lower bits the register.
      always_comb begin
        tgt_sel = '0;
        tgt_sel[i_addr[HB_ADDRW-1 -: SELW]] = 1'b1;
        tgt_off = i_addr[HB_OFFW-1:0];
      end

    end else begin : g_range

      hb_addr_t base_addr;
      hb_addr_t end_addr;
      logic     found;

      // Walk the map from target 0 up.
      // The first match wins, later ones are ignored.
      always_comb begin
        tgt_sel   = '0;
        tgt_off   = '0;
        found     = 1'b0;
        base_addr = '0;
        end_addr  = '0;
        for (int k = 0; k < HB_NTGT; k++) begin
          base_addr = HB_BASE_VEC[k*HB_ADDRW +: HB_ADDRW];
          end_addr  = base_addr + HB_SPAN_VEC[k*HB_ADDRW +: HB_ADDRW];
          if (!found && (i_addr >= base_addr) && (i_addr <= end_addr)) begin
            found      = 1'b1;
            tgt_sel[k] = 1'b1;
            tgt_off    = HB_OFFW'(i_addr - base_addr);
          end
        end
      end

    end
  endgenerate

  // Strobe qualified by the select.
  // A strobe that hits nothing turns into a miss.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_tgt_rq <= '0;
      o_miss   <= 1'b0;
    end else begin
      o_tgt_rq <= {HB_NTGT{i_rq}} & tgt_sel;
      o_miss   <= i_rq & ~(|tgt_sel);
    end
  end

  // Request payload shared by all targets.
  always_ff @(posedge clk) begin
    if (i_rq) begin
      o_offset <= tgt_off;
      o_wr     <= i_wr;
      o_wdata  <= i_wdata;
    end
  end

endmodule

// File: source/hb_map_pkg.sv
package hb_map_pkg;

  import hb_bus_pkg::*;

  // Number of register targets behind the expander.
  parameter int HB_NTGT = 8;

  // Base address per target, target 0 in the lowest field.
  // Target 5 overlaps target 4 at 18 and 19.
  // Addresses 22 and 23 belong to no target.
  parameter logic [HB_NTGT*HB_ADDRW-1:0] HB_BASE_VEC = {
    5'd28,
    5'd24,
    5'd18,
    5'd16,
    5'd12,
    5'd8,
    5'd4,
    5'd0
  };

  // Span per target, end address is base plus span.
  parameter logic [HB_NTGT*HB_ADDRW-1:0] HB_SPAN_VEC = {
    5'd3,
    5'd3,
    5'd3,
    5'd3,
    5'd3,
    5'd3,
    5'd3,
    5'd3
  };

  // Targets 2 and 6 reject writes.
  parameter logic [HB_NTGT-1:0] HB_RO_MASK = 8'b0100_0100;

endpackage

// File: source/hb_bus_pkg.sv
package hb_bus_pkg;

  // Address width seen by the initiator.
  parameter int HB_ADDRW = 5;

  // Request and response data width.
  parameter int HB_DATAW = 32;

  // Register offset width inside one target.
  parameter int HB_OFFW = 2;

  // Registers per target.
  parameter int HB_NREG = 2 ** HB_OFFW;

  // Response status values carried on the error flag.
  parameter logic HB_RESP_OK  = 1'b0;
  parameter logic HB_RESP_ERR = 1'b1;

  // One data word on the bus.
  typedef logic [HB_DATAW-1:0] hb_data_t;

  // One initiator address.
  typedef logic [HB_ADDRW-1:0] hb_addr_t;

endpackage
